/* flash_pkg.sv */
`default_nettype none

package flash_pkg;

   ////////////////////////////////////////////////////////////
   // frame field widths
   ////////////////////////////////////////////////////////////
   localparam int BITS_INST    = 8;   // opcode
   localparam int BITS_ADDR    = 24;  // flash byte address
   localparam int BITS_BYTE    = 8;
   localparam int MAX_RX_BYTES = 2;   // longest read-back (READ2)
   localparam int RX_BITS      = BITS_BYTE * MAX_RX_BYTES;
   localparam int FRAME_BITS   = BITS_INST + BITS_ADDR + BITS_BYTE; // 40, PP1 frame
   localparam int TX_CNT_BITS  = 6;   // holds up to FRAME_BITS
   localparam int RX_CNT_BITS  = 5;   // holds up to RX_BITS

   ////////////////////////////////////////////////////////////
   // M25P16 opcodes, the subset this controller issues
   ////////////////////////////////////////////////////////////
   localparam logic [BITS_INST-1:0] INST_WREN = 8'h06; // set write enable latch
   localparam logic [BITS_INST-1:0] INST_WRDI = 8'h04; // clear write enable latch
   localparam logic [BITS_INST-1:0] INST_BE   = 8'hC7; // bulk erase
   localparam logic [BITS_INST-1:0] INST_RDSR = 8'h05; // read status register
   localparam logic [BITS_INST-1:0] INST_READ = 8'h03; // read data bytes
   localparam logic [BITS_INST-1:0] INST_PP   = 8'h02; // page program

   // tx / rx bit counts per frame shape
   localparam logic [TX_CNT_BITS-1:0] TX_OP      = TX_CNT_BITS'(BITS_INST);
   localparam logic [TX_CNT_BITS-1:0] TX_OP_ADDR = TX_CNT_BITS'(BITS_INST + BITS_ADDR);
   localparam logic [TX_CNT_BITS-1:0] TX_OP_ADDR_DATA = TX_CNT_BITS'(FRAME_BITS);
   localparam logic [RX_CNT_BITS-1:0] RX_NONE = '0;
   localparam logic [RX_CNT_BITS-1:0] RX_ONE  = RX_CNT_BITS'(BITS_BYTE);
   localparam logic [RX_CNT_BITS-1:0] RX_TWO  = RX_CNT_BITS'(RX_BITS);

   ////////////////////////////////////////////////////////////
   // APB register map, byte offsets
   ////////////////////////////////////////////////////////////
   localparam int APB_ADDR_BITS = 5;
   localparam logic [APB_ADDR_BITS-1:0] REG_CMD    = 5'd0;  // wo launch, rd last code
   localparam logic [APB_ADDR_BITS-1:0] REG_ADDR   = 5'd4;  // 24-bit flash address
   localparam logic [APB_ADDR_BITS-1:0] REG_WDATA  = 5'd8;  // PP1 data byte
   localparam logic [APB_ADDR_BITS-1:0] REG_STATUS = 5'd12; // bit 0 busy
   localparam logic [APB_ADDR_BITS-1:0] REG_RDATA  = 5'd16; // read-back word

   // host command codes, low 3 bits of a REG_CMD write
   typedef enum logic [2:0] {
      CMD_WREN  = 3'd0,
      CMD_WRDI  = 3'd1,
      CMD_BE    = 3'd2,
      CMD_RDSR  = 3'd3,
      CMD_READ1 = 3'd4,
      CMD_READ2 = 3'd5,
      CMD_PP1   = 3'd6
   } flash_cmd_e;

   typedef struct packed {
      flash_cmd_e           cmd;
      logic [BITS_ADDR-1:0] addr;
      logic [BITS_BYTE-1:0] wdata;
   } flash_req_t;

   typedef struct packed {
      logic [FRAME_BITS-1:0]  tx;     // left-aligned, MSB goes out first
      logic [TX_CNT_BITS-1:0] tx_cnt;
      logic [RX_CNT_BITS-1:0] rx_cnt; // 0 when nothing comes back
   } spi_frame_t;

   typedef struct packed {
      logic sck;
      logic cs_n;
      logic mosi;
   } spi_pins_t;

   // first received byte in the upper half
   typedef logic [RX_BITS-1:0] rdata_t;

endpackage

`default_nettype wire

/* flash_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_apb_regs (
   input  wire logic                                 clk_in,
   input  wire logic                                 enable_latch_reset,
   // APB slave
   input  wire logic                                 psel,
   input  wire logic                                 penable,
   input  wire logic                                 pwrite,
   input  wire logic [flash_pkg::APB_ADDR_BITS-1:0] paddr,
   input  wire logic [31:0]                          pwdata,
   output logic      [31:0]                          prdata,
   output logic                                      pready,
   output logic                                      pslverr,
   // sequencer side
   input  wire logic                                 busy,
   input  wire flash_pkg::rdata_t                    rdata,
   output logic                                      start,
   output flash_pkg::flash_req_t                     req
);

   logic access;     // APB access phase
   logic wr;
   logic off_ok;     // paddr hits a mapped register
   logic cmd_wr;
   logic cmd_blocked;
   logic start_q;

   flash_pkg::flash_cmd_e                cmd_q;
   logic [flash_pkg::BITS_ADDR-1:0]      addr_q;
   logic [flash_pkg::BITS_BYTE-1:0]      wdata_q;

   ////////////////////////////////////////////////////////////
   // access decode
   ////////////////////////////////////////////////////////////
   assign access = psel & penable;
   assign wr     = access & pwrite;
   assign cmd_wr = wr & (paddr == flash_pkg::REG_CMD);

   // start already pulsed but busy not yet up counts as busy too
   assign cmd_blocked = busy | start_q;

   always_comb begin
      case (paddr)
         flash_pkg::REG_CMD,
         flash_pkg::REG_ADDR,
         flash_pkg::REG_WDATA,
         flash_pkg::REG_STATUS,
         flash_pkg::REG_RDATA: off_ok = 1'b1;
         default:              off_ok = 1'b0;
      endcase
   end

   assign pready  = 1'b1;                                     // zero wait states
   assign pslverr = access & (~off_ok | (cmd_wr & cmd_blocked)); // back-pressure or bad offset

   ////////////////////////////////////////////////////////////
   // register file and launch
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_in or posedge enable_latch_reset) begin
      if (enable_latch_reset) begin
         start_q <= 1'b0;
         cmd_q   <= flash_pkg::CMD_WREN;
         addr_q  <= '0;
         wdata_q <= '0;
      end else begin
         start_q <= cmd_wr & ~cmd_blocked; // one cycle, accepted writes only
         if (cmd_wr && !cmd_blocked)
            cmd_q <= flash_pkg::flash_cmd_e'(pwdata[2:0]);
         if (wr && paddr == flash_pkg::REG_ADDR)
            addr_q <= pwdata[flash_pkg::BITS_ADDR-1:0];
         if (wr && paddr == flash_pkg::REG_WDATA)
            wdata_q <= pwdata[flash_pkg::BITS_BYTE-1:0];
      end
   end

   // read mux, unmapped offsets read zero
   always_comb begin
      case (paddr)
         flash_pkg::REG_CMD:    prdata = {29'd0, cmd_q};
         flash_pkg::REG_ADDR:   prdata = {8'd0, addr_q};
         flash_pkg::REG_WDATA:  prdata = {24'd0, wdata_q};
         flash_pkg::REG_STATUS: prdata = {31'd0, cmd_blocked};
         flash_pkg::REG_RDATA:  prdata = {16'd0, rdata};
         default:               prdata = '0;
      endcase
   end

   assign start     = start_q;
   assign req.cmd   = cmd_q;
   assign req.addr  = addr_q;
   assign req.wdata = wdata_q;

endmodule

`default_nettype wire

/* flash_cmd_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_cmd_seq (
   input  wire logic                           clk_in,
   input  wire logic                           enable_latch_reset,
   // from register file
   input  wire logic                           start,
   input  wire flash_pkg::flash_req_t          req,
   output logic                                busy,
   output flash_pkg::rdata_t                   rdata,
   // to / from shifter
   output logic                                go,
   output flash_pkg::spi_frame_t               frame,
   input  wire logic                           done,
   input  wire logic [flash_pkg::RX_BITS-1:0]  rx_bits
);

   logic                  busy_q;
   logic                  go_q;
   flash_pkg::rdata_t     rdata_q;
   flash_pkg::spi_frame_t frame_q;

   ////////////////////////////////////////////////////////////
   // command decode into an instruction frame
   ////////////////////////////////////////////////////////////
   function automatic flash_pkg::spi_frame_t build_frame(input flash_pkg::flash_req_t r);
      logic [flash_pkg::BITS_INST-1:0] op;
      flash_pkg::spi_frame_t           f;
      f.tx_cnt = flash_pkg::TX_OP;
      f.rx_cnt = flash_pkg::RX_NONE;
      case (r.cmd)
         flash_pkg::CMD_WREN: op = flash_pkg::INST_WREN;
         flash_pkg::CMD_WRDI: op = flash_pkg::INST_WRDI;
         flash_pkg::CMD_BE:   op = flash_pkg::INST_BE;
         flash_pkg::CMD_RDSR: begin
            op       = flash_pkg::INST_RDSR;
            f.rx_cnt = flash_pkg::RX_ONE;           // status byte
         end
         flash_pkg::CMD_READ1: begin
            op       = flash_pkg::INST_READ;
            f.tx_cnt = flash_pkg::TX_OP_ADDR;
            f.rx_cnt = flash_pkg::RX_ONE;
         end
         flash_pkg::CMD_READ2: begin
            op       = flash_pkg::INST_READ;
            f.tx_cnt = flash_pkg::TX_OP_ADDR;
            f.rx_cnt = flash_pkg::RX_TWO;           // address auto-increments in flash
         end
         flash_pkg::CMD_PP1: begin
            op       = flash_pkg::INST_PP;
            f.tx_cnt = flash_pkg::TX_OP_ADDR_DATA;
         end
         default: op = flash_pkg::INST_WRDI; // code 7 is undefined and harmless to the array
      endcase
      // one layout for every command and tx_cnt decides how much goes out
      f.tx = {op, r.addr, r.wdata};
      return f;
   endfunction

   ////////////////////////////////////////////////////////////
   // transaction control
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_in or posedge enable_latch_reset) begin
      if (enable_latch_reset) begin
         busy_q  <= 1'b0;
         go_q    <= 1'b0;
         rdata_q <= '0;
      end else begin
         go_q <= start;                  // go lines up with busy rising
         if (start) begin
            busy_q <= 1'b1;
         end else if (done) begin
            busy_q <= 1'b0;
            // left-align so the unused low byte shifts in as zero
            if (frame_q.rx_cnt != flash_pkg::RX_NONE)
               rdata_q <= rx_bits << (flash_pkg::RX_BITS - int'(frame_q.rx_cnt));
         end
      end
   end

   // frame held stable for the whole transaction
   always_ff @(posedge clk_in) begin
      if (start)
         frame_q <= build_frame(req);
   end

   assign busy  = busy_q;
   assign go    = go_q;
   assign frame = frame_q;
   assign rdata = rdata_q;

endmodule

`default_nettype wire

/* flash_spi_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_spi_shifter (
   input  wire logic                          clk_in,
   input  wire logic                          enable_latch_reset,
   input  wire logic                          go,
   input  wire flash_pkg::spi_frame_t         frame,
   output logic                               done,
   output logic [flash_pkg::RX_BITS-1:0]      rx_bits,
   output flash_pkg::spi_pins_t               pins,
   input  wire logic                          miso
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SEND,   // opcode, address, data out on mosi
      ST_RECV,   // read-back bits in on miso
      ST_FINISH  // two-cycle hold before cs_n rises
   } shift_state_e;

   shift_state_e                          state_q;
   logic                                  cs_n_q;
   logic                                  sck_q;   // divide-by-two phase, doubles as sck
   logic                                  mosi_q;
   logic                                  done_q;
   logic [flash_pkg::TX_CNT_BITS-1:0]     bit_cnt_q;
   logic [flash_pkg::RX_CNT_BITS-1:0]     rx_cnt_q;
   logic [flash_pkg::FRAME_BITS-1:0]      tx_sr_q;
   logic [flash_pkg::RX_BITS-1:0]         rx_sr_q;
   logic                                  load;
   logic                                  tx_shift;
   logic                                  rx_sample;

   assign load      = (state_q == ST_IDLE) & go;
   assign tx_shift  = (state_q == ST_SEND) & sck_q & (bit_cnt_q > 1); // falling sck, more bits
   assign rx_sample = (state_q == ST_RECV) & ~sck_q;                   // rising sck

   ////////////////////////////////////////////////////////////
   // frame FSM, one bit per two clk_in cycles
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_in or posedge enable_latch_reset) begin
      if (enable_latch_reset) begin
         state_q   <= ST_IDLE;
         cs_n_q    <= 1'b1;
         sck_q     <= 1'b0;
         mosi_q    <= 1'b0;
         done_q    <= 1'b0;
         bit_cnt_q <= '0;
         rx_cnt_q  <= '0;
      end else begin
         done_q <= 1'b0;
         case (state_q)
            ST_IDLE: begin
               if (go) begin
                  state_q   <= ST_SEND;
                  cs_n_q    <= 1'b0;
                  mosi_q    <= frame.tx[flash_pkg::FRAME_BITS-1]; // first bit during sck low
                  bit_cnt_q <= frame.tx_cnt;
                  rx_cnt_q  <= frame.rx_cnt;
               end
            end
            ST_SEND: begin
               sck_q <= ~sck_q;
               if (tx_shift) begin
                  bit_cnt_q <= bit_cnt_q - 1'b1;
                  mosi_q    <= tx_sr_q[flash_pkg::FRAME_BITS-2];  // next bit
               end else if (sck_q) begin                          // last tx bit ends
                  mosi_q <= 1'b0;
                  if (rx_cnt_q != '0) begin
                     state_q   <= ST_RECV;
                     bit_cnt_q <= flash_pkg::TX_CNT_BITS'(rx_cnt_q);
                  end else begin
                     state_q   <= ST_FINISH;
                     bit_cnt_q <= 1;
                  end
               end
            end
            ST_RECV: begin
               sck_q <= ~sck_q;
               if (sck_q) begin
                  if (bit_cnt_q > 1) begin
                     bit_cnt_q <= bit_cnt_q - 1'b1;
                  end else begin
                     state_q   <= ST_FINISH;
                     bit_cnt_q <= 1;
                  end
               end
            end
            default: begin                        // ST_FINISH, sck stays low
               if (bit_cnt_q != '0) begin
                  bit_cnt_q <= bit_cnt_q - 1'b1;
               end else begin
                  state_q <= ST_IDLE;
                  cs_n_q  <= 1'b1;
                  done_q  <= 1'b1;
               end
            end
         endcase
      end
   end

   // shift registers
   always_ff @(posedge clk_in) begin
      if (load) begin
         tx_sr_q <= frame.tx;
         rx_sr_q <= '0;                  // short reads leave upper bits zero
      end else begin
         if (tx_shift)
            tx_sr_q <= tx_sr_q << 1;
         if (rx_sample)
            rx_sr_q <= {rx_sr_q[flash_pkg::RX_BITS-2:0], miso}; // MSB first
      end
   end

   assign done    = done_q;
   assign rx_bits = rx_sr_q;
   assign pins    = '{sck: sck_q, cs_n: cs_n_q, mosi: mosi_q};

endmodule

`default_nettype wire

/* flash_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_ctrl_top (
   input  wire logic                                 clk_in,
   input  wire logic                                 enable_latch_reset,
   // APB slave
   input  wire logic                                 psel,
   input  wire logic                                 penable,
   input  wire logic                                 pwrite,
   input  wire logic [flash_pkg::APB_ADDR_BITS-1:0] paddr,
   input  wire logic [31:0]                          pwdata,
   output logic      [31:0]                          prdata,
   output logic                                      pready,
   output logic                                      pslverr,
   // serial flash
   output flash_pkg::spi_pins_t                      pins,
   input  wire logic                                 miso
);

   logic                           start;
   logic                           busy;
   logic                           go;
   logic                           done;
   logic [flash_pkg::RX_BITS-1:0]  rx_bits;
   flash_pkg::flash_req_t          req;
   flash_pkg::rdata_t              rdata;
   flash_pkg::spi_frame_t          frame;

   ////////////////////////////////////////////////////////////
   // APB regs -> command sequencer -> SPI shifter
   ////////////////////////////////////////////////////////////
   flash_apb_regs i_regs (
      .clk_in, .enable_latch_reset, .psel, .penable, .pwrite, .paddr, .pwdata,
      .prdata, .pready, .pslverr, .busy, .rdata, .start, .req
   );

   flash_cmd_seq i_seq (
      .clk_in, .enable_latch_reset, .start, .req, .busy, .rdata,
      .go, .frame, .done, .rx_bits
   );

   flash_spi_shifter i_shift (
      .clk_in, .enable_latch_reset, .go, .frame, .done, .rx_bits, .pins, .miso
   );

endmodule

`default_nettype wire

/* tb_flash_model.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_flash_model (
   input  wire flash_pkg::spi_pins_t pins,
   output logic                      miso
);

   localparam int MEM_BYTES = 256; // address window, upper address bits ignored

   logic [7:0]  mem [0:MEM_BYTES-1];
   logic        wel;       // write enable latch
   logic [7:0]  op;
   logic [23:0] addr;
   logic [7:0]  data;      // PP data byte
   logic [7:0]  status;
   logic [7:0]  rd_ptr;
   logic        cs_prev;
   logic        sck_prev;
   int          bit_cnt;   // bits seen since cs_n fell

   ////////////////////////////////////////////////////////////
   // SPI mode 0 slave, edges found from the previous pin state
   ////////////////////////////////////////////////////////////
   initial begin
      for (int i = 0; i < MEM_BYTES; i++)
         mem[8'(i)] = 8'(i) ^ 8'hA5;              // power-up contents
      wel      = 1'b0;
      miso     = 1'b0;
      op       = '0;
      addr     = '0;
      data     = '0;
      rd_ptr   = '0;
      bit_cnt  = 0;
      cs_prev  = 1'b1;
      sck_prev = 1'b0;
      forever begin
         @(pins.sck or pins.cs_n);
         status = {6'd0, wel, 1'b0};              // WIP always 0
         if (cs_prev === 1'b1 && pins.cs_n === 1'b0) begin
            bit_cnt = 0;                          // selected, new instruction
         end else if (cs_prev === 1'b0 && pins.cs_n === 1'b1) begin
            miso = 1'b0;
            // writes take effect on deselect, only for complete frames
            case (op)
               flash_pkg::INST_WREN: if (bit_cnt == 8) wel = 1'b1;
               flash_pkg::INST_WRDI: if (bit_cnt == 8) wel = 1'b0;
               flash_pkg::INST_BE: begin
                  if (bit_cnt == 8 && wel) begin
                     for (int i = 0; i < MEM_BYTES; i++)
                        mem[8'(i)] = 8'hFF;       // erased state
                     wel = 1'b0;
                  end
               end
               flash_pkg::INST_PP: begin
                  if (bit_cnt == 40 && wel) begin
                     mem[addr[7:0]] = data;
                     wel = 1'b0;
                  end
               end
               default: ;
            endcase
         end
         if (pins.cs_n === 1'b0 && sck_prev === 1'b0 && pins.sck === 1'b1) begin
            // rising sck, mosi in
            if (bit_cnt < 8)
               op = {op[6:0], pins.mosi};
            else if (bit_cnt < 32)
               addr = {addr[22:0], pins.mosi};
            else if (bit_cnt < 40)
               data = {data[6:0], pins.mosi};
            bit_cnt++;
         end else if (pins.cs_n === 1'b0 && sck_prev === 1'b1 && pins.sck === 1'b0) begin
            // falling sck, next read-back bit out
            if (op == flash_pkg::INST_RDSR && bit_cnt >= 8) begin
               miso = status[3'(7 - (bit_cnt - 8) % 8)];
            end else if (op == flash_pkg::INST_READ && bit_cnt >= 32) begin
               rd_ptr = addr[7:0] + 8'((bit_cnt - 32) / 8); // wraps in the window
               miso   = mem[rd_ptr][3'(7 - (bit_cnt - 32) % 8)];
            end
         end
         cs_prev  = pins.cs_n;
         sck_prev = pins.sck;
      end
   end

endmodule

`default_nettype wire

/* tb_flash_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_flash_ctrl;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_PP       = 20;  // program and read-back rounds
   localparam int NUM_RD2      = 5;   // two-byte reads per test
   localparam int POLL_LIMIT   = 100; // status reads before giving up
   localparam int WD_MARGIN    = 4;
   localparam logic [flash_pkg::APB_ADDR_BITS-1:0] REG_BAD_WR = 5'd20; // unmapped
   localparam logic [flash_pkg::APB_ADDR_BITS-1:0] REG_BAD_RD = 5'd28;
   localparam flash_pkg::spi_pins_t PINS_IDLE = '{sck: 1'b0, cs_n: 1'b1, mosi: 1'b0};

   logic                                 clk_in;
   logic                                 enable_latch_reset;
   logic                                 psel;
   logic                                 penable;
   logic                                 pwrite;
   logic [flash_pkg::APB_ADDR_BITS-1:0] paddr;
   logic [31:0]                          pwdata;
   logic [31:0]                          prdata;
   logic                                 pready;
   logic                                 pslverr;
   flash_pkg::spi_pins_t                 pins;
   logic                                 miso;

   // expected flash and controller state
   logic [7:0]        exp_mem [0:255];
   logic              exp_wel;
   flash_pkg::rdata_t exp_rdata;
   logic [23:0]       cur_addr;  // last value written to REG_ADDR
   logic [7:0]        cur_wdata;
   logic [31:0]       lfsr_q;
   int                err_count    = 0;
   int                checks       = 0;
   int                tests_run    = 0;
   int                tests_failed = 0;
   int                test_errs    = 0;
   string             test_name;

   flash_ctrl_top i_dut (
      .clk_in, .enable_latch_reset, .psel, .penable, .pwrite, .paddr, .pwdata,
      .prdata, .pready, .pslverr, .pins, .miso
   );

   tb_flash_model i_flash (.pins, .miso);

   initial begin
      clk_in = 1'b0;
      forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
   end

   ////////////////////////////////////////////////////////////
   // random source and frame lengths
   ////////////////////////////////////////////////////////////
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // x^32+x^22+x^2+x+1
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};          // one step per bit
      end
   endtask

   function automatic int frame_cycles(input flash_pkg::flash_cmd_e c);
      int tx;
      int rx;
      tx = 8;
      rx = 0;
      case (c)
         flash_pkg::CMD_RDSR:  rx = 8;
         flash_pkg::CMD_READ1: begin tx = 32; rx = 8; end
         flash_pkg::CMD_READ2: begin tx = 32; rx = 16; end
         flash_pkg::CMD_PP1:   tx = 40;
         default: ;
      endcase
      return 2 * (tx + rx) + 2;
   endfunction

   ////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////
   task automatic check_rdata(input string name, input flash_pkg::rdata_t got,
                              input flash_pkg::rdata_t exp);
      checks++;
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_status(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_err(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
         err_count++;
      end
   endtask

   task automatic check_pins(input string name, input flash_pkg::spi_pins_t got,
                             input flash_pkg::spi_pins_t exp);
      checks++;
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
         err_count++;
      end
   endtask

   ////////////////////////////////////////////////////////////
   // APB master, entered and left on a falling edge
   ////////////////////////////////////////////////////////////
   task automatic apb_access(input logic wr, input logic [flash_pkg::APB_ADDR_BITS-1:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rd_data,
                             output logic err);
      psel    = 1'b1;                            // setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(negedge clk_in);
      penable = 1'b1;                            // access phase
      #(CLK_PERIOD / 4);                         // mid low phase, outputs settled
      rd_data = prdata;
      err     = pslverr;
      if (pready !== 1'b1) begin
         $display("pready was low during an APB access at %0t ns", $time);
         err_count++;
      end
      @(negedge clk_in);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic write_reg(input logic [flash_pkg::APB_ADDR_BITS-1:0] addr,
                            input logic [31:0] wdata);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b1, addr, wdata, rd, err);
      check_err("pslverr", err, 1'b0);
   endtask

   task automatic wait_idle();
      logic [31:0] rd;
      logic        err;
      int          polls;
      polls = 0;
      do begin
         apb_access(1'b0, flash_pkg::REG_STATUS, 32'd0, rd, err);
         polls++;
      end while (rd[0] && polls < POLL_LIMIT);
      if (rd[0]) begin
         $display("busy stayed high after %0d status reads at %0t ns", polls, $time);
         err_count++;
      end
   endtask

   // expected effect of a completed command
   task automatic model_cmd(input flash_pkg::flash_cmd_e cmd);
      logic [7:0] a;
      a = cur_addr[7:0];
      case (cmd)
         flash_pkg::CMD_WREN:  exp_wel = 1'b1;
         flash_pkg::CMD_WRDI:  exp_wel = 1'b0;
         flash_pkg::CMD_RDSR:  exp_rdata = {6'd0, exp_wel, 1'b0, 8'h00};
         flash_pkg::CMD_READ1: exp_rdata = {exp_mem[a], 8'h00};
         flash_pkg::CMD_READ2: exp_rdata = {exp_mem[a], exp_mem[a + 8'd1]};
         flash_pkg::CMD_BE: begin
            if (exp_wel) begin
               for (int i = 0; i < 256; i++)
                  exp_mem[8'(i)] = 8'hFF;
               exp_wel = 1'b0;
            end
         end
         flash_pkg::CMD_PP1: begin
            if (exp_wel) begin
               exp_mem[a] = cur_wdata;
               exp_wel    = 1'b0;
            end
         end
         default: ;
      endcase
   endtask

   task automatic run_cmd(input flash_pkg::flash_cmd_e cmd);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b1, flash_pkg::REG_CMD, {29'd0, cmd}, rd, err);
      check_err("pslverr", err, 1'b0);
      wait_idle();
      model_cmd(cmd);
   endtask

   task automatic check_rdata_reg(input flash_pkg::rdata_t exp);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b0, flash_pkg::REG_RDATA, 32'd0, rd, err);
      check_err("pslverr", err, 1'b0);
      check_rdata("rdata", rd[15:0], exp);
   endtask

   task automatic set_addr_data(input logic [23:0] addr, input logic [7:0] wdata);
      cur_addr  = addr;
      cur_wdata = wdata;
      write_reg(flash_pkg::REG_ADDR, {8'd0, addr});
      write_reg(flash_pkg::REG_WDATA, {24'd0, wdata});
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errs = err_count;
      tests_run++;
   endtask

   task automatic finish_test();
      if (err_count == test_errs) begin
         $display("test %0d %s: ok", tests_run, test_name);
      end else begin
         tests_failed++;
         $display("test %0d %s: FAILED with %0d errors", tests_run, test_name,
                  err_count - test_errs);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial begin : main
      logic [31:0] r;
      logic [31:0] rd;
      logic        err;
      enable_latch_reset = 1'b1;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      lfsr_q    = 32'd1;                         // seed
      exp_wel   = 1'b0;
      exp_rdata = '0;
      cur_addr  = '0;
      cur_wdata = '0;
      for (int i = 0; i < 256; i++)
         exp_mem[8'(i)] = 8'(i) ^ 8'hA5;         // same power-up fill as the flash
      repeat (RESET_CYCLES) @(negedge clk_in);
      enable_latch_reset = 1'b0;

      start_test("reset state");
      apb_access(1'b0, flash_pkg::REG_STATUS, 32'd0, rd, err);
      check_status("busy", rd[0], 1'b0);
      check_rdata_reg(16'h0000);
      check_pins("pins", pins, PINS_IDLE);
      finish_test();

      start_test("write enable latch");
      run_cmd(flash_pkg::CMD_WREN);
      run_cmd(flash_pkg::CMD_RDSR);
      check_rdata_reg(16'h0200);
      run_cmd(flash_pkg::CMD_WRDI);
      run_cmd(flash_pkg::CMD_RDSR);
      check_rdata_reg(16'h0000);
      finish_test();

      start_test("page program and read");
      for (int n = 0; n < NUM_PP; n++) begin
         rand_bits(24, r);
         cur_addr = r[23:0];
         rand_bits(8, r);
         set_addr_data(cur_addr, r[7:0]);
         run_cmd(flash_pkg::CMD_WREN);
         run_cmd(flash_pkg::CMD_PP1);
         run_cmd(flash_pkg::CMD_READ1);
         check_rdata_reg(exp_rdata);
      end
      rand_bits(24, r);                          // no WREN, byte must survive
      set_addr_data(r[23:0], ~exp_mem[r[7:0]]);
      run_cmd(flash_pkg::CMD_PP1);
      run_cmd(flash_pkg::CMD_READ1);
      check_rdata_reg(exp_rdata);
      finish_test();

      start_test("two-byte read");
      for (int n = 0; n < NUM_RD2; n++) begin
         rand_bits(24, r);
         set_addr_data(r[23:0], cur_wdata);
         run_cmd(flash_pkg::CMD_READ2);
         check_rdata_reg(exp_rdata);
      end
      finish_test();

      start_test("bulk erase");
      run_cmd(flash_pkg::CMD_WREN);
      run_cmd(flash_pkg::CMD_BE);
      for (int n = 0; n < NUM_RD2; n++) begin
         rand_bits(24, r);
         set_addr_data(r[23:0], cur_wdata);
         run_cmd(flash_pkg::CMD_READ2);
         check_rdata_reg(16'hFFFF);
      end
      run_cmd(flash_pkg::CMD_RDSR);
      check_rdata_reg(16'h0000);                 // latch cleared by BE
      finish_test();

      start_test("busy back-pressure and bad offset");
      rand_bits(24, r);
      set_addr_data(r[23:0], ~exp_mem[r[7:0]]);
      run_cmd(flash_pkg::CMD_WREN);
      apb_access(1'b1, flash_pkg::REG_CMD, {29'd0, flash_pkg::CMD_READ2}, rd, err);
      check_err("pslverr", err, 1'b0);
      apb_access(1'b0, flash_pkg::REG_STATUS, 32'd0, rd, err);
      check_status("busy", rd[0], 1'b1);
      apb_access(1'b1, flash_pkg::REG_CMD, {29'd0, flash_pkg::CMD_PP1}, rd, err);
      check_err("pslverr", err, 1'b1);           // rejected, PP never runs
      wait_idle();
      model_cmd(flash_pkg::CMD_READ2);
      check_rdata_reg(exp_rdata);
      run_cmd(flash_pkg::CMD_READ1);
      check_rdata_reg(exp_rdata);
      run_cmd(flash_pkg::CMD_RDSR);
      check_rdata_reg(16'h0200);                 // latch still set
      run_cmd(flash_pkg::CMD_WRDI);
      apb_access(1'b1, REG_BAD_WR, 32'd0, rd, err);
      check_err("pslverr", err, 1'b1);
      apb_access(1'b0, REG_BAD_RD, 32'd0, rd, err);
      check_err("pslverr", err, 1'b1);
      check_pins("pins", pins, PINS_IDLE);
      finish_test();

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, err_count);
      if (err_count == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   // run length bound from the frames the sequence issues
   initial begin : watchdog
      int frames;
      frames = (NUM_PP + 3) * frame_cycles(flash_pkg::CMD_WREN)
             + 2 * frame_cycles(flash_pkg::CMD_WRDI)
             + frame_cycles(flash_pkg::CMD_BE)
             + 4 * frame_cycles(flash_pkg::CMD_RDSR)
             + (NUM_PP + 2) * frame_cycles(flash_pkg::CMD_READ1)
             + (2 * NUM_RD2 + 1) * frame_cycles(flash_pkg::CMD_READ2)
             + (NUM_PP + 1) * frame_cycles(flash_pkg::CMD_PP1);
      #((RESET_CYCLES + WD_MARGIN * frames) * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the tests did not finish",
               RESET_CYCLES + WD_MARGIN * frames);
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
flash_pkg.sv
flash_apb_regs.sv
flash_cmd_seq.sv
flash_spi_shifter.sv
flash_ctrl_top.sv
tb_flash_model.sv
tb_flash_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the flash controller testbench, pass only if the log says so
cd "$(dirname "$0")" \
   && rm -f sim.log \
   && verilator --binary --timing -f project.f --top-module tb_flash_ctrl -o sim_flash \
   && ./obj_dir/sim_flash | tee sim.log \
   && grep -q "^All tests passed$" sim.log \
   && echo "simulation PASS" \
   || { echo "simulation FAIL"; exit 1; }
